// ==== Makefile ====
SIM := obj_dir/Vrv_core_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): vlog.f rtl/*.sv rtl/*.svh verif/*.sv verif/*.svh
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module rv_core_tb

# the simulator status is ignored, the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee run.log
	grep -q "^\*\*\* TEST PASSED \*\*\*$$" run.log

clean:
	rm -rf obj_dir run.log

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_alu import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  alu_op_e             op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            // set when a is below b, compared as signed values
            ALU_SLT: begin
                result = {{(`RV_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            ALU_SLTU: begin
                result = {{(`RV_XLEN-1){1'b0}}, (a < b)};
            end
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // branches compare through ALU_SUB and test this flag
    assign zero = (result == '0);

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core import rv_pkg::*; (
    input  logic                      CLK,
    input  logic                      RESET_N,
    input  logic [`RV_XLEN-1:0]       idata,
    output logic [`RV_ADDR_WIDTH-1:0] iaddr,
    output logic [`RV_ADDR_WIDTH-1:0] daddr,
    input  logic [`RV_XLEN-1:0]       ddata_r,
    output logic [`RV_XLEN-1:0]       ddata_w,
    output logic                      d_rw
);

    // the PC keeps two byte bits below the word address
    localparam int PC_W = `RV_ADDR_WIDTH + 2;

    logic [PC_W-1:0]     pc;
    logic [PC_W-1:0]     pc_plus4;
    logic [PC_W-1:0]     pc_target;
    logic [PC_W-1:0]     pc_next;
    logic                take;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_zero;
    logic [`RV_XLEN-1:0] wb_data;
    logic [`RV_XLEN-1:0] pc_ext;
    logic [`RV_XLEN-1:0] pc4_ext;

    rv_ctrl_if ctrl_if ();

    rv_decoder decoder_i (
        .instr (idata),
        .ctrl  (ctrl_if.dec)
    );

    rv_imm_gen imm_gen_i (
        .instr (idata),
        .imm   (imm)
    );

    // register writes stay off while reset is asserted
    rv_regfile regfile_i (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1_addr (idata[19:15]),
        .rs2_addr (idata[24:20]),
        .rd_addr  (idata[11:7]),
        .rd_data  (wb_data),
        .we       (ctrl_if.reg_write & RESET_N),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign pc_ext  = {{(`RV_XLEN-PC_W){1'b0}}, pc};
    assign pc4_ext = {{(`RV_XLEN-PC_W){1'b0}}, pc_plus4};

    always_comb begin
        case (ctrl_if.a_sel)
            A_PC:    op_a = pc_ext;
            A_ZERO:  op_a = '0;
            default: op_a = rs1_data;
        endcase
    end

    assign op_b = ctrl_if.b_imm ? imm : rs2_data;

    rv_alu alu_i (
        .a      (op_a),
        .b      (op_b),
        .op     (ctrl_if.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // BEQ wants a zero difference, BNE a non-zero one
    assign take      = (ctrl_if.branch && (alu_zero == !ctrl_if.branch_ne)) || ctrl_if.jump;
    assign pc_plus4  = pc + PC_W'(4);
    assign pc_target = pc + imm[PC_W-1:0];
    assign pc_next   = take ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (ctrl_if.wb_sel)
            WB_MEM:  wb_data = ddata_r;
            WB_PC4:  wb_data = pc4_ext;
            default: wb_data = alu_result;
        endcase
    end

    assign iaddr   = pc[PC_W-1:2];
    assign daddr   = alu_result[`RV_ADDR_WIDTH+1:2];
    assign ddata_w = rs2_data;
    assign d_rw    = ctrl_if.mem_write & RESET_N;

    // once out of reset the fetch address must always be fully known
    a_iaddr_known : assert property (
        @(posedge CLK) disable iff (!RESET_N)
        !$isunknown(iaddr)
    ) else $error("iaddr has unknown bits");

endmodule

// ==== rtl/rv_ctrl_if.sv ====
`timescale 1ns/1ps

interface rv_ctrl_if import rv_pkg::*; ();

    alu_op_e alu_op;
    a_sel_e  a_sel;
    logic    b_imm;
    logic    reg_write;
    logic    mem_write;
    wb_sel_e wb_sel;
    logic    branch;
    logic    branch_ne;
    logic    jump;

    // the decoder produces every control
    modport dec (
        output alu_op, a_sel, b_imm, reg_write, mem_write,
        output wb_sel, branch, branch_ne, jump
    );

    // the datapath only consumes them
    modport dp (
        input alu_op, a_sel, b_imm, reg_write, mem_write,
        input wb_sel, branch, branch_ne, jump
    );

endinterface

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decoder import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr,
    rv_ctrl_if.dec              ctrl
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       bit30;

    // funct3 plus the alternate bit select the register and immediate ALU ops
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    always_comb begin
        // idle defaults, an unknown opcode leaves them all in place
        ctrl.alu_op    = ALU_ADD;
        ctrl.a_sel     = A_RS1;
        ctrl.b_imm     = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.wb_sel    = WB_ALU;
        ctrl.branch    = 1'b0;
        ctrl.branch_ne = 1'b0;
        ctrl.jump      = 1'b0;

        case (opcode)
            OP: begin
                ctrl.alu_op    = alu_from_funct(funct3, bit30);
                ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                // bit 30 is part of the immediate except for the right shifts
                ctrl.alu_op    = alu_from_funct(funct3, bit30 && (funct3 == 3'b101));
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            LOAD: begin
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MEM;
            end
            STORE: begin
                ctrl.b_imm     = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            BRANCH: begin
                // only BEQ and BNE are taken, other compares fall through
                ctrl.alu_op    = ALU_SUB;
                ctrl.branch    = (funct3[2:1] == 2'b00);
                ctrl.branch_ne = funct3[0];
            end
            JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_PC4;
            end
            LUI: begin
                ctrl.a_sel     = A_ZERO;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            AUIPC: begin
                ctrl.a_sel     = A_PC;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/rv_imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_imm_gen import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            // I format
            OP_IMM, LOAD: begin
                imm = {{21{instr[31]}}, instr[30:20]};
            end
            // S format
            STORE: begin
                imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            end
            // B format, offset in halfwords so bit 0 is always zero
            BRANCH: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            // U format
            LUI, AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            // J format
            JAL: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== rtl/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and register width, instruction slicing assumes 32
`define RV_XLEN 32

// width of the word address seen on iaddr and daddr
`define RV_ADDR_WIDTH 10

// architectural register count, x0 included
`define RV_NREGS 32

`endif

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // operations the ALU can perform
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // source of the first ALU operand
    typedef enum logic [1:0] {
        A_RS1  = 2'd0,
        A_PC   = 2'd1,
        A_ZERO = 2'd2
    } a_sel_e;

    // source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
    input  logic               CLK,
    input  logic               RESET_N,
    input  logic [4:0]         rs1_addr,
    input  logic [4:0]         rs2_addr,
    input  logic [4:0]         rd_addr,
    input  logic [`RV_XLEN-1:0] rd_data,
    input  logic               we,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 is cleared by reset and never written afterwards
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // reads are combinational, a write shows up for the next instruction
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 must still read zero no matter what was written before
    a_x0_zero : assert property (
        @(posedge CLK) disable iff (!RESET_N)
        (rs1_addr == 5'd0) |-> (rs1_data == '0)
    ) else $error("x0 read back a non-zero value");

endmodule

// ==== verif/rv_core_tests.svh ====
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

// per ALU operation, bit 3 is instruction bit 30 and bits 2:0 are funct3
localparam logic [3:0] FUNCT [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};

// with imm_form low src holds rs2 in its low five bits
function automatic logic [31:0] enc_alu(input alu_op_e op, input logic imm_form,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] src);
    logic [3:0] f;
    f = FUNCT[op];
    if (imm_form) begin
        return {src, rs1, f[2:0], rd, OP_IMM};
    end
    return {1'b0, f[3], 5'b0, src[4:0], rs1, f[2:0], rd, OP};
endfunction

function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
endfunction

function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, LOAD};
endfunction

function automatic logic [31:0] enc_br(input logic ne, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], BRANCH};
endfunction

function automatic logic [31:0] enc_u(input opcode_e opc, input logic [4:0] rd,
                                      input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
endfunction

// LUI takes the rounded upper part so the ADDI sign extension lands on v
task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(LUI, rd, hi[31:12]));
    emit(enc_alu(ALU_ADD, 1'b1, rd, rd, v[11:0]));
endtask

task automatic finish_test();
    int halt;
    halt = prog_len;
    emit(enc_jal(5'd0, 21'd0));
    release_reset();
    run_until_halt(halt);
    compare_stores();
endtask

task automatic test_reset_seq();
    start_test("reset and sequencing");
    // the store at word 0 shows that d_rw stays low while reset holds the core
    emit(enc_sw(5'd0, 5'd0, 12'd0));
    for (int i = 0; i < 6; i++) begin
        emit(enc_alu(ALU_ADD, 1'b1, 5'd0, 5'd0, 12'd0));
    end
    expect_store(0, 32'd0);
    finish_test();
    for (int i = 0; i < 7; i++) begin
        check_next_fetch(i, i + 1);
    end
endtask

task automatic test_alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm;
    alu_op_e     op;
    int          slot;
    start_test("alu operations");
    // a negative first operand separates the signed and unsigned compares
    a = lcg_next() | 32'h8000_0000;
    b = lcg_next() & 32'h7fff_ffff;
    load_const(5'd1, a);
    load_const(5'd2, b);
    slot = 0;
    for (int i = 0; i < 10; i++) begin
        op = alu_op_e'(i);
        emit(enc_alu(op, 1'b0, 5'd3, 5'd1, 12'd2));
        emit(enc_sw(5'd3, 5'd0, 12'(4 * slot)));
        expect_store(slot, ref_alu(op, a, b));
        slot++;
        if (op != ALU_SUB) begin
            r   = lcg_next();
            imm = r[27:16];
            if (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA) begin
                imm = {1'b0, op == ALU_SRA, 5'b0, imm[4:0]};
            end
            emit(enc_alu(op, 1'b1, 5'd4, 5'd1, imm));
            emit(enc_sw(5'd4, 5'd0, 12'(4 * slot)));
            expect_store(slot, ref_alu(op, a, {{20{imm[11]}}, imm}));
            slot++;
        end
    end
    finish_test();
endtask

task automatic test_load_store();
    logic [31:0] v;
    start_test("load and store");
    v = lcg_next();
    load_const(5'd1, v);
    emit(enc_alu(ALU_ADD, 1'b1, 5'd5, 5'd0, 12'h040));
    emit(enc_sw(5'd1, 5'd5, 12'd8));
    emit(enc_lw(5'd6, 5'd5, 12'd8));
    emit(enc_alu(ALU_ADD, 1'b1, 5'd6, 5'd6, 12'd1));
    emit(enc_sw(5'd6, 5'd5, 12'hffc));
    // x0 ignores the write and still stores zero
    emit(enc_alu(ALU_ADD, 1'b1, 5'd0, 5'd0, 12'd5));
    emit(enc_sw(5'd0, 5'd5, 12'd16));
    expect_store((64 + 8) / 4, v);
    expect_store((64 - 4) / 4, v + 32'd1);
    expect_store((64 + 16) / 4, 32'd0);
    finish_test();
endtask

task automatic test_branches();
    logic [31:0] r;
    logic        ne;
    logic        same;
    int          br_at [4];
    logic        br_taken [4];
    start_test("branches");
    r = lcg_next();
    load_const(5'd1, r);
    load_const(5'd2, r);
    load_const(5'd3, r ^ 32'h0000_0100);
    for (int c = 0; c < 4; c++) begin
        ne          = c[1];
        same        = !c[0];
        br_taken[c] = ne ? !same : same;
        emit(enc_alu(ALU_ADD, 1'b1, 5'd10, 5'd0, 12'(16 * c + 1)));
        emit(enc_alu(ALU_ADD, 1'b1, 5'd11, 5'd0, 12'(16 * c + 2)));
        br_at[c] = prog_len;
        // a taken branch skips the first marker store
        emit(enc_br(ne, 5'd1, same ? 5'd2 : 5'd3, 13'd8));
        emit(enc_sw(5'd10, 5'd0, 12'(8 * c)));
        emit(enc_sw(5'd11, 5'd0, 12'(8 * c + 4)));
        if (!br_taken[c]) begin
            expect_store(2 * c, 16 * c + 1);
        end
        expect_store(2 * c + 1, 16 * c + 2);
    end
    finish_test();
    for (int c = 0; c < 4; c++) begin
        check_next_fetch(br_at[c], br_taken[c] ? br_at[c] + 2 : br_at[c] + 1);
    end
endtask

task automatic test_jal_upper();
    logic [31:0] r;
    int          jal_at;
    int          auipc_at;
    start_test("jal auipc lui");
    r = lcg_next();
    emit(enc_alu(ALU_ADD, 1'b1, 5'd0, 5'd0, 12'd0));
    jal_at = prog_len;
    emit(enc_jal(5'd1, 21'd8));
    emit(enc_sw(5'd0, 5'd0, 12'd0));
    emit(enc_sw(5'd1, 5'd0, 12'd4));
    auipc_at = prog_len;
    emit(enc_u(AUIPC, 5'd2, r[31:12]));
    emit(enc_sw(5'd2, 5'd0, 12'd8));
    emit(enc_u(LUI, 5'd3, r[19:0]));
    emit(enc_sw(5'd3, 5'd0, 12'd12));
    expect_store(1, 32'(4 * jal_at + 4));
    expect_store(2, 32'(4 * auipc_at) + {r[31:12], 12'b0});
    expect_store(3, {r[19:0], 12'b0});
    finish_test();
    check_next_fetch(jal_at, jal_at + 2);
endtask

`endif

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int AW              = `RV_ADDR_WIDTH;
    localparam int CLK_PERIOD      = 10;
    localparam int N_TESTS         = 5;
    localparam int CYCLES_PER_TEST = 300;

    logic                CLK;
    logic                RESET_N;
    logic [`RV_XLEN-1:0] idata;
    logic [AW-1:0]       iaddr;
    logic [AW-1:0]       daddr;
    logic [`RV_XLEN-1:0] ddata_r;
    logic [`RV_XLEN-1:0] ddata_w;
    logic                d_rw;

    logic [31:0]   rom [1 << AW];
    logic [31:0]   ram [1 << AW];
    logic [AW-1:0] got_addr [$];
    logic [31:0]   got_data [$];
    logic [AW-1:0] exp_addr [$];
    logic [31:0]   exp_data [$];
    logic [AW-1:0] iaddr_trace [$];
    logic [31:0]   lcg_state;
    int            prog_len;
    int            mismatches = 0;
    int            failures = 0;

    rv_core dut_i (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .idata   (idata),
        .iaddr   (iaddr),
        .daddr   (daddr),
        .ddata_r (ddata_r),
        .ddata_w (ddata_w),
        .d_rw    (d_rw)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // both memories answer in the same cycle, the RAM writes on the rising edge
    assign idata   = rom[iaddr];
    assign ddata_r = ram[daddr];

    always @(posedge CLK) begin
        if (d_rw) begin
            ram[daddr] <= ddata_w;
            got_addr.push_back(daddr);
            got_data.push_back(ddata_w);
        end
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // reference results straight from the RV32I definitions
    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0]  sh;
        logic [63:0] ext;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return (a[31] != b[31]) ? 32'(a[31]) : 32'(a < b);
            ALU_SLTU: return 32'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return ext[31:0];
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic emit(input logic [31:0] instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_store(input int word, input logic [31:0] value);
        exp_addr.push_back(AW'(word));
        exp_data.push_back(value);
    endtask

    // reset goes low first so the program can be loaded while the core is held
    task automatic start_test(input string name);
        @(negedge CLK);
        RESET_N = 1'b0;
        $display("running test: %s", name);
        for (int i = 0; i < (1 << AW); i++) begin
            rom[i] = '0;
            ram[i] = 32'hc0de_0000 + i;
        end
        prog_len = 0;
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic release_reset();
        repeat (4) begin
            @(negedge CLK);
            check_addr("iaddr", iaddr, '0);
            check_bit("d_rw", d_rw, 1'b0);
        end
        RESET_N = 1'b1;
    endtask

    // the halt word is a jump to itself, reaching it means the program is done
    task automatic run_until_halt(input int halt);
        int cycles;
        cycles = 0;
        iaddr_trace.delete();
        iaddr_trace.push_back(iaddr);
        while (iaddr_trace[$] != AW'(halt) && cycles < CYCLES_PER_TEST) begin
            @(negedge CLK);
            cycles++;
            iaddr_trace.push_back(iaddr);
        end
        if (iaddr_trace[$] != AW'(halt)) begin
            failures++;
            $display("core did not reach the halt word %0d within %0d cycles", halt, cycles);
        end
    endtask

    task automatic compare_stores();
        if (got_addr.size() != exp_addr.size()) begin
            failures++;
            $display("saw %0d stores where %0d were expected", got_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check_addr("daddr", got_addr[i], exp_addr[i]);
            check_word("ddata_w", got_data[i], exp_data[i]);
        end
    endtask

    task automatic check_next_fetch(input int from, input int to);
        int found;
        found = 0;
        for (int i = 0; i + 1 < iaddr_trace.size(); i++) begin
            if (found == 0 && iaddr_trace[i] == AW'(from)) begin
                check_addr("iaddr", iaddr_trace[i + 1], AW'(to));
                found = 1;
            end
        end
        if (found == 0) begin
            failures++;
            $display("word %0d was never fetched before another fetch", from);
        end
    endtask

    `include "rv_core_tests.svh"

    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        CLK       = 1'b0;
        RESET_N   = 1'b0;
        lcg_state = 32'd7;
        prog_len  = 0;
        test_reset_seq();
        test_alu_ops();
        test_load_store();
        test_branches();
        test_jal_upper();
        $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
+incdir+verif
rtl/rv_pkg.sv
rtl/rv_ctrl_if.sv
rtl/rv_decoder.sv
rtl/rv_imm_gen.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_core.sv
verif/rv_core_tb.sv
